// File: logic/frame_fifo_pkg.sv
// frame buffer FIFO bridge definitions
// pixel and AXI beat types plus fixed sizes shared by the datapath
package frame_fifo_pkg;

    localparam int PIXEL_W = 32;                        // video source word
    localparam int BEAT_W  = 256;                       // DDR AXI data width

    typedef logic [PIXEL_W-1:0] pixel_t;                // one pixel word
    typedef logic [BEAT_W-1:0]  beat_t;                 // one AXI beat

    // slices per beat with pixel 0 in the low slice
    localparam int PIXELS_PER_BEAT = BEAT_W / PIXEL_W;

    localparam int CLEAR_HISTORY = 16;                  // clear sample depth

endpackage

// File: logic/chan_clear_ctrl.sv
// channel clear controller
// edge detects a clear level over a sample history, stretches and delays the pulse
module chan_clear_ctrl import frame_fifo_pkg::*; #(
    parameter int HOLDOFF_CYCLES = 100
) (
    input  logic ddrphy_clkin,
    input  logic rst_n,
    input  logic clear_req,                             // raw clear level
    output logic clear,                                 // delayed clear pulse to FIFO
    output logic holdoff_done                           // holdoff counter saturated
);

    localparam int CNT_W = $clog2(HOLDOFF_CYCLES + 1);

    logic [CLEAR_HISTORY-1:0] history;                  // bit 0 is newest
    logic                     clear_pulse;
    logic [CNT_W-1:0]         holdoff_cnt;

    always_ff @(posedge ddrphy_clkin or negedge rst_n)
    begin
        if (!rst_n)
        begin
            history <= '0;
        end
        else
        begin
            history <= {history[CLEAR_HISTORY-2:0], clear_req};
        end
    end

    // high until the level has aged through the whole history
    always_ff @(posedge ddrphy_clkin or negedge rst_n)
    begin
        if (!rst_n)
        begin
            clear_pulse <= 1'b0;
            clear       <= 1'b0;
        end
        else
        begin
            clear_pulse <= history[0] && !history[CLEAR_HISTORY-1];
            clear       <= clear_pulse;                 // one cycle later so counters settle
        end
    end

    always_ff @(posedge ddrphy_clkin or negedge rst_n)
    begin
        if (!rst_n)
        begin
            holdoff_cnt <= '0;
        end
        else if (clear_pulse)
        begin
            holdoff_cnt <= '0;                          // restart on every new clear
        end
        else if (holdoff_cnt != CNT_W'(HOLDOFF_CYCLES))
        begin
            holdoff_cnt <= holdoff_cnt + 1'b1;
        end
    end

    assign holdoff_done = (holdoff_cnt == CNT_W'(HOLDOFF_CYCLES));

endmodule

// File: logic/pixel_pack_fifo.sv
// write channel pixel packer
// gathers 8 pixels per beat into a beat FIFO and flags a line ready for AXI
module pixel_pack_fifo import frame_fifo_pkg::*; #(
    parameter int LINE_PIXELS = 64,
    parameter int WR_DEPTH    = 16
) (
    input  logic   ddrphy_clkin,
    input  logic   rst_n,
    input  logic   clear,
    input  logic   pixel_wr_en,
    input  pixel_t pixel_wr_data,
    output logic   pixel_wr_full,
    input  logic   axi_wr_en,
    output beat_t  axi_wr_data,
    output logic   axi_wr_req
);

    localparam int LINE_BEATS = LINE_PIXELS / PIXELS_PER_BEAT;
    localparam int SLOT_W     = $clog2(PIXELS_PER_BEAT);
    localparam int PTR_W      = $clog2(WR_DEPTH);
    localparam int LVL_W      = $clog2(WR_DEPTH + 1);

    beat_t             mem [WR_DEPTH];
    beat_t             pack_reg;                        // partial beat
    beat_t             beat_next;
    logic [SLOT_W-1:0] slot;
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [LVL_W-1:0]  level;                           // beats held
    logic              push;
    logic              beat_done;
    logic              pop;

    assign pixel_wr_full = (level == LVL_W'(WR_DEPTH));
    assign push          = pixel_wr_en && !pixel_wr_full;
    assign beat_done     = push && (slot == SLOT_W'(PIXELS_PER_BEAT - 1));
    assign pop           = axi_wr_en && (level != '0);
    assign axi_wr_data   = mem[rd_ptr];                 // oldest beat always shown

    always_comb
    begin
        beat_next = pack_reg;
        beat_next[slot*PIXEL_W +: PIXEL_W] = pixel_wr_data;
    end

    always_ff @(posedge ddrphy_clkin)
    begin
        if (push)
        begin
            pack_reg <= beat_next;
        end
        if (beat_done)
        begin
            mem[wr_ptr] <= beat_next;
        end
    end

    always_ff @(posedge ddrphy_clkin or negedge rst_n)
    begin
        if (!rst_n)
        begin
            slot   <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else if (clear)
        begin
            slot   <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else
        begin
            if (pixel_wr_full)
                slot <= '0;                             // back-pressure drops the open group
            else if (push)
                slot <= slot + 1'b1;
            if (beat_done)
                wr_ptr <= (wr_ptr == PTR_W'(WR_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(WR_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (beat_done && !pop)
                level <= level + 1'b1;
            else if (pop && !beat_done)
                level <= level - 1'b1;
        end
    end

    always_ff @(posedge ddrphy_clkin or negedge rst_n)
    begin
        if (!rst_n)
            axi_wr_req <= 1'b0;
        else
            axi_wr_req <= (level >= LVL_W'(LINE_BEATS)); // a full line is waiting
    end

endmodule

// File: logic/pixel_unpack_fifo.sv
// read channel pixel unpacker
// buffers AXI beats and serves them slice by slice, asks for more below a line
module pixel_unpack_fifo import frame_fifo_pkg::*; #(
    parameter int LINE_PIXELS = 64,
    parameter int RD_DEPTH    = 32
) (
    input  logic   ddrphy_clkin,
    input  logic   rst_n,
    input  logic   clear,
    input  logic   holdoff_done,
    input  logic   axi_rd_en,
    input  beat_t  axi_rd_data,
    output logic   axi_rd_full,
    input  logic   pixel_rd_en,
    output pixel_t pixel_rd_data,
    output logic   pixel_rd_empty,
    output logic   axi_rd_req
);

    localparam int LINE_BEATS = LINE_PIXELS / PIXELS_PER_BEAT;
    localparam int SLOT_W     = $clog2(PIXELS_PER_BEAT);
    localparam int PTR_W      = $clog2(RD_DEPTH);
    localparam int LVL_W      = $clog2(RD_DEPTH + 1);

    beat_t             mem [RD_DEPTH];
    logic [SLOT_W-1:0] slice;                           // next pixel in head beat
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [LVL_W-1:0]  level;                           // includes a partly read beat
    logic              push;
    logic              pop;
    logic              beat_free;

    assign axi_rd_full    = (level == LVL_W'(RD_DEPTH));
    assign pixel_rd_empty = (level == '0);
    assign push           = axi_rd_en && !axi_rd_full;  // beats beyond depth are lost
    assign pop            = pixel_rd_en && !pixel_rd_empty;
    assign beat_free      = pop && (slice == SLOT_W'(PIXELS_PER_BEAT - 1));
    assign pixel_rd_data  = mem[rd_ptr][slice*PIXEL_W +: PIXEL_W];

    always_ff @(posedge ddrphy_clkin)
    begin
        if (push)
        begin
            mem[wr_ptr] <= axi_rd_data;
        end
    end

    always_ff @(posedge ddrphy_clkin or negedge rst_n)
    begin
        if (!rst_n)
        begin
            slice  <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else if (clear)
        begin
            slice  <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else
        begin
            if (pop)
                slice <= slice + 1'b1;                  // wraps to slice 0 on the last one
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(RD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (beat_free)
                rd_ptr <= (rd_ptr == PTR_W'(RD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !beat_free)
                level <= level + 1'b1;
            else if (beat_free && !push)
                level <= level - 1'b1;
        end
    end

    // request another line once less than a line of beats remains
    always_ff @(posedge ddrphy_clkin or negedge rst_n)
    begin
        if (!rst_n)
            axi_rd_req <= 1'b0;
        else
            axi_rd_req <= holdoff_done && (level <= LVL_W'(LINE_BEATS - 1));
    end

endmodule

// File: logic/frame_fifo_top.sv
// frame buffer FIFO bridge top level
// one write packer and one read unpacker, each with its own clear controller
module frame_fifo_top import frame_fifo_pkg::*; #(
    parameter int LINE_PIXELS    = 64,
    parameter int WR_DEPTH       = 16,
    parameter int RD_DEPTH       = 32,
    parameter int HOLDOFF_CYCLES = 100
) (
    input  logic   ddrphy_clkin,
    input  logic   rst_n,

    input  logic   pixel_wr_en,                         // video source side
    input  pixel_t pixel_wr_data,
    input  logic   pixel_wr_rst,
    output logic   pixel_wr_full,
    input  logic   axi_wr_en,                           // AXI write master side
    output beat_t  axi_wr_data,
    output logic   axi_wr_req,

    input  logic   axi_rd_en,                           // AXI read master side
    input  beat_t  axi_rd_data,
    output logic   axi_rd_full,
    output logic   axi_rd_req,
    input  logic   pixel_rd_en,                         // display side
    output pixel_t pixel_rd_data,
    input  logic   pixel_rd_rst,
    output logic   pixel_rd_empty
);

    logic wr_clear;
    logic rd_clear;
    logic rd_holdoff_done;

    chan_clear_ctrl #(
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) u_wr_clear (
        .ddrphy_clkin   (ddrphy_clkin),
        .rst_n          (rst_n),
        .clear_req      (pixel_wr_rst),
        .clear          (wr_clear),
        .holdoff_done   ()                              // write side has no holdoff
    );

    chan_clear_ctrl #(
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) u_rd_clear (
        .ddrphy_clkin   (ddrphy_clkin),
        .rst_n          (rst_n),
        .clear_req      (pixel_rd_rst),
        .clear          (rd_clear),
        .holdoff_done   (rd_holdoff_done)
    );

    pixel_pack_fifo #(
        .LINE_PIXELS    (LINE_PIXELS),
        .WR_DEPTH       (WR_DEPTH)
    ) u_pack (
        .ddrphy_clkin   (ddrphy_clkin),
        .rst_n          (rst_n),
        .clear          (wr_clear),
        .pixel_wr_en    (pixel_wr_en),
        .pixel_wr_data  (pixel_wr_data),
        .pixel_wr_full  (pixel_wr_full),
        .axi_wr_en      (axi_wr_en),
        .axi_wr_data    (axi_wr_data),
        .axi_wr_req     (axi_wr_req)
    );

    pixel_unpack_fifo #(
        .LINE_PIXELS    (LINE_PIXELS),
        .RD_DEPTH       (RD_DEPTH)
    ) u_unpack (
        .ddrphy_clkin   (ddrphy_clkin),
        .rst_n          (rst_n),
        .clear          (rd_clear),
        .holdoff_done   (rd_holdoff_done),
        .axi_rd_en      (axi_rd_en),
        .axi_rd_data    (axi_rd_data),
        .axi_rd_full    (axi_rd_full),
        .pixel_rd_en    (pixel_rd_en),
        .pixel_rd_data  (pixel_rd_data),
        .pixel_rd_empty (pixel_rd_empty),
        .axi_rd_req     (axi_rd_req)
    );

endmodule

// File: sim/tb_clk_gen.sv
// testbench clock and reset source
// 10 ns clock, reset held low for the first 4 cycles
module tb_clk_gen (
    output logic ddrphy_clkin,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        ddrphy_clkin = 1'b0;
        forever #5 ddrphy_clkin = ~ddrphy_clkin;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (4) @(posedge ddrphy_clkin);
        @(negedge ddrphy_clkin);                        // release away from the sampling edge
        rst_n = 1'b1;
    end

endmodule

// File: sim/frame_fifo_checker.sv
// frame FIFO bridge scoreboard
// queue model of both channels and their clear controllers, compared on rising edges
module frame_fifo_checker import frame_fifo_pkg::*; #(
    parameter int LINE_PIXELS    = 64,
    parameter int WR_DEPTH       = 16,
    parameter int RD_DEPTH       = 32,
    parameter int HOLDOFF_CYCLES = 100
) (
    input  logic   ddrphy_clkin,
    input  logic   rst_n,
    input  logic   pixel_wr_en,
    input  pixel_t pixel_wr_data,
    input  logic   pixel_wr_rst,
    input  logic   pixel_wr_full,
    input  logic   axi_wr_en,
    input  beat_t  axi_wr_data,
    input  logic   axi_wr_req,
    input  logic   axi_rd_en,
    input  beat_t  axi_rd_data,
    input  logic   axi_rd_full,
    input  logic   axi_rd_req,
    input  logic   pixel_rd_en,
    input  pixel_t pixel_rd_data,
    input  logic   pixel_rd_rst,
    input  logic   pixel_rd_empty,
    output int     error_count,
    output int     check_count,
    output int     wr_beats                             // beats the model holds
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LINE_BEATS = LINE_PIXELS / PIXELS_PER_BEAT;

    beat_t  wr_q[$];
    beat_t  rd_q[$];
    bit     wr_hist[$];                                 // index 0 is the oldest sample
    bit     rd_hist[$];
    beat_t  pack_beat;
    pixel_t exp_pixel;
    int     pack_cnt;
    int     rd_slice;
    int     hold_cnt;
    bit     wr_pulse;
    bit     wr_clr;
    bit     rd_pulse;
    bit     rd_clr;
    bit     wr_req_m;
    bit     rd_req_m;
    bit     wr_pop;
    bit     rd_pop;
    bit     rd_push;

    task automatic check_value(input string name, input beat_t got, input beat_t exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Mismatch %s at %0t: got %0h expected %0h", name, $time, got, exp);
        end
    endtask

    task automatic reset_model();
        int i;
        wr_q.delete();
        rd_q.delete();
        wr_hist.delete();
        rd_hist.delete();
        for (i = 0; i < CLEAR_HISTORY; i++)
        begin
            wr_hist.push_back(1'b0);
            rd_hist.push_back(1'b0);
        end
        pack_cnt = 0;
        rd_slice = 0;
        hold_cnt = 0;
        {wr_pulse, wr_clr, rd_pulse, rd_clr, wr_req_m, rd_req_m} = '0;
    endtask

    task automatic compare_outputs();
        check_value("pixel_wr_full", beat_t'(pixel_wr_full), beat_t'(wr_q.size() == WR_DEPTH));
        check_value("axi_wr_req", beat_t'(axi_wr_req), beat_t'(wr_req_m));
        if (wr_q.size() > 0)
            check_value("axi_wr_data", axi_wr_data, wr_q[0]);
        check_value("axi_rd_full", beat_t'(axi_rd_full), beat_t'(rd_q.size() == RD_DEPTH));
        check_value("pixel_rd_empty", beat_t'(pixel_rd_empty), beat_t'(rd_q.size() == 0));
        check_value("axi_rd_req", beat_t'(axi_rd_req), beat_t'(rd_req_m));
        if (rd_q.size() > 0)
        begin
            exp_pixel = rd_q[0][rd_slice*PIXEL_W +: PIXEL_W];
            check_value("pixel_rd_data", beat_t'(pixel_rd_data), beat_t'(exp_pixel));
        end
    endtask

    task automatic step_write();
        wr_req_m = (wr_q.size() >= LINE_BEATS);
        if (wr_clr)
        begin
            wr_q.delete();
            pack_cnt = 0;
        end
        else
        begin
            wr_pop = axi_wr_en && (wr_q.size() > 0);
            if (wr_q.size() == WR_DEPTH)
                pack_cnt = 0;                           // open group lost under back-pressure
            else if (pixel_wr_en)
            begin
                pack_beat[pack_cnt*PIXEL_W +: PIXEL_W] = pixel_wr_data;
                pack_cnt++;
            end
            if (wr_pop)
                void'(wr_q.pop_front());
            if (pack_cnt == PIXELS_PER_BEAT)
            begin
                wr_q.push_back(pack_beat);
                pack_cnt = 0;
            end
        end
    endtask

    task automatic step_read();
        rd_req_m = (hold_cnt == HOLDOFF_CYCLES) && (rd_q.size() < LINE_BEATS);
        if (rd_clr)
        begin
            rd_q.delete();
            rd_slice = 0;
        end
        else
        begin
            rd_pop  = pixel_rd_en && (rd_q.size() > 0);
            rd_push = axi_rd_en && (rd_q.size() < RD_DEPTH);
            if (rd_pop)
            begin
                rd_slice++;
                if (rd_slice == PIXELS_PER_BEAT)
                begin
                    rd_slice = 0;
                    void'(rd_q.pop_front());
                end
            end
            if (rd_push)
                rd_q.push_back(axi_rd_data);
        end
    endtask

    // new request when the newest sample is set and the oldest is not
    task automatic step_clears();
        if (rd_pulse)
            hold_cnt = 0;
        else if (hold_cnt < HOLDOFF_CYCLES)
            hold_cnt++;
        wr_clr   = wr_pulse;
        rd_clr   = rd_pulse;
        wr_pulse = wr_hist[CLEAR_HISTORY-1] && !wr_hist[0];
        rd_pulse = rd_hist[CLEAR_HISTORY-1] && !rd_hist[0];
        wr_hist.push_back(pixel_wr_rst);
        rd_hist.push_back(pixel_rd_rst);
        void'(wr_hist.pop_front());
        void'(rd_hist.pop_front());
    endtask

    always @(posedge ddrphy_clkin)
    begin
        if (!rst_n)
        begin
            reset_model();
        end
        else
        begin
            compare_outputs();                          // pre-edge state first
            step_write();
            step_read();
            step_clears();
        end
        wr_beats = wr_q.size();
    end

endmodule

// File: sim/frame_fifo_properties.sv
// frame FIFO bridge properties
// flag and write data stability rules checked on the top level
module frame_fifo_properties import frame_fifo_pkg::*; (
    input logic  ddrphy_clkin,
    input logic  rst_n,
    input logic  pixel_wr_en,
    input logic  pixel_wr_full,
    input logic  axi_wr_en,
    input beat_t axi_wr_data,
    input logic  axi_wr_req,
    input logic  axi_rd_full,
    input logic  axi_rd_req,
    input logic  pixel_rd_empty,
    input logic  wr_clear
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;

    rd_req_not_full: assert property (@(posedge ddrphy_clkin) disable iff (!rst_n)
        !(axi_rd_req && !pixel_rd_empty && axi_rd_full))
    else
    begin
        failures++;
        $error("read request raised while the read FIFO is full");
    end

    wr_flags_after_reset: assert property (@(posedge ddrphy_clkin)
        $rose(rst_n) |-> (!pixel_wr_full && !axi_wr_req))
    else
    begin
        failures++;
        $error("write flags not low in the cycle after reset");
    end

    // no push, no pop and no clear leaves the oldest beat in place
    wr_data_stable: assert property (@(posedge ddrphy_clkin) disable iff (!rst_n)
        (!axi_wr_en && !pixel_wr_en && !wr_clear) |=> (axi_wr_data === $past(axi_wr_data)))
    else
    begin
        failures++;
        $error("write beat changed while the write FIFO was idle");
    end

endmodule

bind frame_fifo_top frame_fifo_properties u_props (
    .ddrphy_clkin   (ddrphy_clkin),
    .rst_n          (rst_n),
    .pixel_wr_en    (pixel_wr_en),
    .pixel_wr_full  (pixel_wr_full),
    .axi_wr_en      (axi_wr_en),
    .axi_wr_data    (axi_wr_data),
    .axi_wr_req     (axi_wr_req),
    .axi_rd_full    (axi_rd_full),
    .axi_rd_req     (axi_rd_req),
    .pixel_rd_empty (pixel_rd_empty),
    .wr_clear       (wr_clear)
);

// File: sim/frame_fifo_tb.sv
// frame FIFO bridge testbench
// seeded random pixel and beat traffic with channel clears, driven on falling edges
module frame_fifo_tb import frame_fifo_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LINE_PIXELS    = 64;
    localparam int WR_DEPTH       = 16;
    localparam int RD_DEPTH       = 32;
    localparam int HOLDOFF_CYCLES = 100;
    localparam int PHASE_CYCLES   = 1500;
    localparam int WAIT_LIMIT     = 1000;
    localparam int CLEAR_HOLD     = 20;

    logic   ddrphy_clkin;
    logic   rst_n;
    logic   pixel_wr_en;
    pixel_t pixel_wr_data;
    logic   pixel_wr_rst;
    logic   pixel_wr_full;
    logic   axi_wr_en;
    beat_t  axi_wr_data;
    logic   axi_wr_req;
    logic   axi_rd_en;
    beat_t  axi_rd_data;
    logic   axi_rd_full;
    logic   axi_rd_req;
    logic   pixel_rd_en;
    pixel_t pixel_rd_data;
    logic   pixel_rd_rst;
    logic   pixel_rd_empty;
    integer seed = 9124;
    int     error_count;
    int     check_count;
    int     wr_beats;
    int     wait_cnt;
    bit     timed_out;

    tb_clk_gen u_clk (
        .ddrphy_clkin (ddrphy_clkin),
        .rst_n        (rst_n)
    );

    frame_fifo_top #(
        .LINE_PIXELS    (LINE_PIXELS),
        .WR_DEPTH       (WR_DEPTH),
        .RD_DEPTH       (RD_DEPTH),
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) UUT (.*);

    frame_fifo_checker #(
        .LINE_PIXELS    (LINE_PIXELS),
        .WR_DEPTH       (WR_DEPTH),
        .RD_DEPTH       (RD_DEPTH),
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) u_check (.*);

    task automatic drive_idle();
        pixel_wr_en   = 1'b0;
        pixel_wr_data = '0;
        axi_wr_en     = 1'b0;
        axi_rd_en     = 1'b0;
        axi_rd_data   = '0;
        pixel_rd_en   = 1'b0;
    endtask

    // rates in sixteenths while pixel push and pop run at three quarters
    task automatic drive_traffic(input int wr_pop_rate, input int rd_push_rate);
        beat_t beat;
        int    n;
        int    k;
        for (n = 0; n < PHASE_CYCLES; n++)
        begin
            @(negedge ddrphy_clkin);
            for (k = 0; k < PIXELS_PER_BEAT; k++)
                beat[k*PIXEL_W +: PIXEL_W] = $random(seed);
            pixel_wr_en   = ($random(seed) & 3) != 0;
            pixel_wr_data = $random(seed);
            axi_wr_en     = (wr_beats > 0) && (($random(seed) & 15) < wr_pop_rate);
            axi_rd_en     = ($random(seed) & 15) < rd_push_rate;
            axi_rd_data   = beat;
            pixel_rd_en   = ($random(seed) & 3) != 0;
        end
    endtask

    task automatic clear_channel(input bit rd_side);
        int n;
        @(negedge ddrphy_clkin);
        drive_idle();
        if (rd_side)
            pixel_rd_rst = 1'b1;
        else
            pixel_wr_rst = 1'b1;
        for (n = 0; n < CLEAR_HOLD; n++)
            @(negedge ddrphy_clkin);
        pixel_wr_rst = 1'b0;
        pixel_rd_rst = 1'b0;
        for (n = 0; n < CLEAR_HOLD; n++)
            @(negedge ddrphy_clkin);                    // quiet time before new traffic
    endtask

    initial
    begin
        drive_idle();
        pixel_wr_rst = 1'b0;
        pixel_rd_rst = 1'b0;
        timed_out    = 1'b0;
        wait_cnt     = 0;
        while (rst_n !== 1'b1 && wait_cnt < WAIT_LIMIT)
        begin
            @(posedge ddrphy_clkin);                    // reset moves on the falling edge
            wait_cnt++;
        end
        if (rst_n !== 1'b1)
        begin
            timed_out = 1'b1;
            $display("timeout: reset was never released");
        end
        if (!timed_out)
        begin
            drive_traffic(1, 8);                        // write side backs up, read side fills
            clear_channel(1'b0);
            drive_traffic(12, 1);                       // write side drains, read side runs dry
            clear_channel(1'b1);
            drive_traffic(6, 2);
            @(negedge ddrphy_clkin);
            drive_idle();
            pixel_rd_en = 1'b1;
            axi_wr_en   = (wr_beats > 0);
            wait_cnt    = 0;
            while ((pixel_rd_empty !== 1'b1 || wr_beats != 0) && wait_cnt < WAIT_LIMIT)
            begin
                @(negedge ddrphy_clkin);
                axi_wr_en = (wr_beats > 0);
                wait_cnt++;
            end
            if (pixel_rd_empty !== 1'b1 || wr_beats != 0)
            begin
                timed_out = 1'b1;
                $display("timeout: channels did not drain");
            end
            drive_idle();
            repeat (5) @(negedge ddrphy_clkin);
        end
        $display("checks %0d, mismatches %0d, assertion failures %0d, timeouts %0d",
                 check_count, error_count, UUT.u_props.failures, timed_out);
        if (timed_out || error_count != 0 || UUT.u_props.failures != 0)
        begin
            $display("=== FAIL ===");
        end
        else
        begin
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule

// File: flist.f
logic/frame_fifo_pkg.sv
logic/chan_clear_ctrl.sv
logic/pixel_pack_fifo.sv
logic/pixel_unpack_fifo.sv
logic/frame_fifo_top.sv
sim/tb_clk_gen.sv
sim/frame_fifo_checker.sv
sim/frame_fifo_properties.sv
sim/frame_fifo_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the frame FIFO bridge testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module frame_fifo_tb -Mdir obj_dir -f flist.f \
    && ./obj_dir/Vframe_fifo_tb +verilator+error+limit+100 > sim.log 2>&1 \
    || echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -q "^=== PASS ===$" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
